/* logic/soc_config.svh */
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// bus widths
`define ADDR_WIDTH      32
`define DATA_WIDTH      32
`define STRB_WIDTH      4
`define ID_WIDTH        4
`define RESP_WIDTH      2

// axi response codes
`define RESP_OKAY       2'd0
`define RESP_SLVERR     2'd2
`define RESP_DECERR     2'd3

// apb window seen from the axi side
`define APB_ADDR_BASE   32'h1FE0_0000
`define APB_ADDR_END    32'h1FE0_FFFF

// 4 KB per slot
`define APB_SLOT_BITS   12
`define APB_SLOT_LED    0
`define APB_SLOT_SYSCTL 1

`define SYSCTL_ID       32'h4C41_0132
`define LED_COUNT       4

`endif

/* logic/soc_pkg.sv */
`include "soc_config.svh"

package soc_pkg;

	// bus vectors
	typedef logic [`ADDR_WIDTH-1:0] addr_t;
	typedef logic [`DATA_WIDTH-1:0] data_t;
	typedef logic [`STRB_WIDTH-1:0] strb_t;

	// axi transaction id, echoed on b and r
	typedef logic [`ID_WIDTH-1:0] axi_id_t;

	// okay, slverr or decerr
	typedef logic [`RESP_WIDTH-1:0] resp_t;

	// one bit per board led
	typedef logic [`LED_COUNT-1:0] led_t;

	// bridge sequencing
	// idle waits for a request, setup and access are the apb phases,
	// resp holds b or r valid until the master takes it
	typedef enum logic [1:0] {
		BR_IDLE,
		BR_SETUP,
		BR_ACCESS,
		BR_RESP
	} bridge_state_t;

endpackage

/* logic/bridge_ctrl.sv */
`timescale 1ns/1ps

module bridge_ctrl import soc_pkg::*; (
	input  logic clk,
	input  logic rst_n,

	// axi handshakes
	input  logic awvalid,
	output logic awready,
	input  logic wvalid,
	output logic wready,
	input  logic arvalid,
	output logic arready,
	output logic bvalid,
	input  logic bready,
	output logic rvalid,
	input  logic rready,

	// apb handshakes
	output logic psel,
	output logic penable,
	input  logic pready,

	// strobes for the request and response buffer
	output logic load_wr,
	output logic load_rd,
	output logic cap_rsp
);

	bridge_state_t state;
	bridge_state_t state_nxt;
	// direction of the transaction in flight
	logic is_wr;
	logic wr_req;
	logic rd_req;
	logic rsp_done;

	// write needs address and data together
	assign wr_req = awvalid & wvalid;
	// read only when no part of a write is waiting
	assign rd_req = arvalid & ~awvalid & ~wvalid;

	// accept only from idle, one transaction at a time
	assign load_wr = (state == BR_IDLE) & wr_req;
	assign load_rd = (state == BR_IDLE) & rd_req;
	assign awready = load_wr;
	assign wready  = load_wr;
	assign arready = load_rd;

	// apb phases
	assign psel    = (state == BR_SETUP) | (state == BR_ACCESS);
	assign penable = (state == BR_ACCESS);
	// slave result captured on the completing access edge
	assign cap_rsp = penable & pready;

	// response channel picked by direction
	assign bvalid   = (state == BR_RESP) & is_wr;
	assign rvalid   = (state == BR_RESP) & ~is_wr;
	assign rsp_done = (bvalid & bready) | (rvalid & rready);

	always_comb begin
		state_nxt = state;
		case (state)
			BR_IDLE: begin
				if (load_wr | load_rd) begin
					state_nxt = BR_SETUP;
				end
			end
			BR_SETUP: state_nxt = BR_ACCESS;
			BR_ACCESS: begin
				// wait states would stretch access here
				if (pready) begin
					state_nxt = BR_RESP;
				end
			end
			BR_RESP: begin
				// back-pressure keeps valid up
				if (rsp_done) begin
					state_nxt = BR_IDLE;
				end
			end
			default: state_nxt = BR_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= BR_IDLE;
			is_wr <= 1'b0;
		end else begin
			state <= state_nxt;
			if (load_wr | load_rd) begin
				is_wr <= load_wr;
			end
		end
	end

endmodule

/* logic/axi_req_buf.sv */
`timescale 1ns/1ps

module axi_req_buf import soc_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    load_wr,
	input  logic    load_rd,
	input  logic    cap_rsp,

	// axi request side
	input  axi_id_t awid,
	input  axi_id_t arid,
	input  addr_t   awaddr,
	input  addr_t   araddr,
	input  data_t   wdata,
	input  strb_t   wstrb,

	// apb result
	input  data_t   prdata,
	input  resp_t   presp,

	// apb request side
	output addr_t   paddr,
	output logic    pwrite,
	output data_t   pwdata,
	output strb_t   pstrb,

	// axi response side
	output axi_id_t bid,
	output axi_id_t rid,
	output resp_t   bresp,
	output resp_t   rresp,
	output data_t   rdata
);

	// id of the transaction in flight
	axi_id_t id_q;
	resp_t   resp_q;

	// direction of the latched request
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pwrite <= 1'b0;
		end else if (load_wr | load_rd) begin
			pwrite <= load_wr;
		end
	end

	// address source follows the accepted channel
	always_ff @(posedge clk) begin
		if (load_wr) begin
			paddr  <= awaddr;
			id_q   <= awid;
			pwdata <= wdata;
			pstrb  <= wstrb;
		end else if (load_rd) begin
			paddr  <= araddr;
			id_q   <= arid;
			// apb reads carry no strobes
			pstrb  <= '0;
		end
	end

	// result of the access phase
	always_ff @(posedge clk) begin
		if (cap_rsp) begin
			resp_q <= presp;
			if (!pwrite) begin
				rdata <= prdata;
			end
		end
	end

	// only one channel is ever valid, so both share the holding regs
	assign bid   = id_q;
	assign rid   = id_q;
	assign bresp = resp_q;
	assign rresp = resp_q;

endmodule

/* logic/apb_mux.sv */
`timescale 1ns/1ps

`include "soc_config.svh"

module apb_mux import soc_pkg::*; (
	input  logic  psel,
	input  addr_t paddr,
	input  data_t led_rdata,
	input  data_t sys_rdata,
	output logic  led_sel,
	output logic  sys_sel,
	output logic  pready,
	output data_t prdata,
	output resp_t presp
);

	// slots that fit in the window
	localparam int SLOT_COUNT = (`APB_ADDR_END - `APB_ADDR_BASE + 1) >> `APB_SLOT_BITS;
	localparam int SLOT_IDX_W = $clog2(SLOT_COUNT);

	logic                  in_window;
	logic [SLOT_IDX_W-1:0] slot;
	logic                  led_hit;
	logic                  sys_hit;

	// window check against the full address
	assign in_window = (paddr >= `APB_ADDR_BASE) && (paddr <= `APB_ADDR_END);
	assign slot      = paddr[`APB_SLOT_BITS +: SLOT_IDX_W];

	assign led_hit = in_window && (slot == SLOT_IDX_W'(`APB_SLOT_LED));
	assign sys_hit = in_window && (slot == SLOT_IDX_W'(`APB_SLOT_SYSCTL));

	// at most one select
	assign led_sel = psel & led_hit;
	assign sys_sel = psel & sys_hit;

	// all slaves zero wait
	// misses complete at once too so the error gets back
	assign pready = psel;

	always_comb begin
		if (led_sel) begin
			prdata = led_rdata;
		end else if (sys_sel) begin
			prdata = sys_rdata;
		end else begin
			prdata = '0;
		end
	end

	// decerr outside, slverr for an empty slot
	always_comb begin
		if (!in_window) begin
			presp = `RESP_DECERR;
		end else if (led_hit | sys_hit) begin
			presp = `RESP_OKAY;
		end else begin
			presp = `RESP_SLVERR;
		end
	end

endmodule

/* logic/led_regs.sv */
`timescale 1ns/1ps

module led_regs import soc_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,

	// apb slave
	input  logic  sel,
	input  logic  penable,
	input  logic  pwrite,
	input  data_t pwdata,
	input  strb_t pstrb,
	output data_t rdata,

	// board pins
	output led_t  led
);

	logic wr_en;

	// any offset in the slot hits the register
	// only byte lane 0 carries led bits
	assign wr_en = sel & penable & pwrite & pstrb[0];

	// update lands on the access edge
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			led <= '0;
		end else if (wr_en) begin
			led <= pwdata[$bits(led_t)-1:0];
		end
	end

	// upper bits read as zero
	assign rdata = data_t'(led);

endmodule

/* logic/sysctl_regs.sv */
`timescale 1ns/1ps

`include "soc_config.svh"

module sysctl_regs import soc_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  sel,
	input  logic  penable,
	input  logic  pwrite,
	input  addr_t paddr,
	input  data_t pwdata,
	input  strb_t pstrb,
	output data_t rdata
);

	// byte offset bits inside a word
	localparam int BYTE_BITS = $clog2(`STRB_WIDTH);

	logic [`APB_SLOT_BITS-BYTE_BITS-1:0] word_idx;
	logic  id_hit;
	logic  scratch_hit;
	data_t scratch;

	assign word_idx    = paddr[`APB_SLOT_BITS-1:BYTE_BITS];
	// offset 0 id, offset 4 scratch
	assign id_hit      = (word_idx == '0);
	assign scratch_hit = (word_idx == 1);

	// id is read only, so only scratch takes writes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			scratch <= '0;
		end else if (sel && penable && pwrite && scratch_hit) begin
			for (int i = 0; i < `STRB_WIDTH; i++) begin
				if (pstrb[i]) begin
					scratch[8*i +: 8] <= pwdata[8*i +: 8];
				end
			end
		end
	end

	// everything else reads zero
	assign rdata = id_hit ? `SYSCTL_ID : (scratch_hit ? scratch : '0);

endmodule

/* logic/periph_top.sv */
`timescale 1ns/1ps

`include "soc_config.svh"

module periph_top (
	input  logic                    clk,
	input  logic                    rst_n,

	// axi write address
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [`ID_WIDTH-1:0]    awid,
	input  logic [`ADDR_WIDTH-1:0]  awaddr,

	// axi write data
	input  logic                    wvalid,
	output logic                    wready,
	input  logic [`DATA_WIDTH-1:0]  wdata,
	input  logic [`STRB_WIDTH-1:0]  wstrb,

	// axi write response
	output logic                    bvalid,
	input  logic                    bready,
	output logic [`ID_WIDTH-1:0]    bid,
	output logic [`RESP_WIDTH-1:0]  bresp,

	// axi read address
	input  logic                    arvalid,
	output logic                    arready,
	input  logic [`ID_WIDTH-1:0]    arid,
	input  logic [`ADDR_WIDTH-1:0]  araddr,

	// axi read data
	output logic                    rvalid,
	input  logic                    rready,
	output logic [`ID_WIDTH-1:0]    rid,
	output logic [`DATA_WIDTH-1:0]  rdata,
	output logic [`RESP_WIDTH-1:0]  rresp,

	output logic [`LED_COUNT-1:0]   led
);

	// bridge control to buffer
	logic                   load_wr;
	logic                   load_rd;
	logic                   cap_rsp;

	// internal apb bus
	logic                   psel;
	logic                   penable;
	logic                   pready;
	logic                   pwrite;
	logic [`ADDR_WIDTH-1:0] paddr;
	logic [`DATA_WIDTH-1:0] pwdata;
	logic [`STRB_WIDTH-1:0] pstrb;
	logic [`DATA_WIDTH-1:0] prdata;
	logic [`RESP_WIDTH-1:0] presp;

	// per slave
	logic                   led_sel;
	logic                   sys_sel;
	logic [`DATA_WIDTH-1:0] led_rdata;
	logic [`DATA_WIDTH-1:0] sys_rdata;

	bridge_ctrl i_bridge_ctrl (
		.clk     (clk    ), .rst_n   (rst_n  ),
		.awvalid (awvalid), .awready (awready),
		.wvalid  (wvalid ), .wready  (wready ),
		.arvalid (arvalid), .arready (arready),
		.bvalid  (bvalid ), .bready  (bready ),
		.rvalid  (rvalid ), .rready  (rready ),
		.psel    (psel   ), .penable (penable), .pready (pready),
		.load_wr (load_wr), .load_rd (load_rd), .cap_rsp (cap_rsp)
	);

	axi_req_buf i_axi_req_buf (
		.clk     (clk    ), .rst_n   (rst_n  ),
		.load_wr (load_wr), .load_rd (load_rd), .cap_rsp (cap_rsp),
		.awid    (awid   ), .arid    (arid   ),
		.awaddr  (awaddr ), .araddr  (araddr ),
		.wdata   (wdata  ), .wstrb   (wstrb  ),
		.prdata  (prdata ), .presp   (presp  ),
		.paddr   (paddr  ), .pwrite  (pwrite ),
		.pwdata  (pwdata ), .pstrb   (pstrb  ),
		.bid     (bid    ), .rid     (rid    ),
		.bresp   (bresp  ), .rresp   (rresp  ), .rdata (rdata)
	);

	apb_mux i_apb_mux (
		.psel      (psel     ), .paddr     (paddr    ),
		.led_rdata (led_rdata), .sys_rdata (sys_rdata),
		.led_sel   (led_sel  ), .sys_sel   (sys_sel  ),
		.pready    (pready   ), .prdata    (prdata   ), .presp (presp)
	);

	led_regs i_led_regs (
		.clk     (clk    ), .rst_n   (rst_n  ),
		.sel     (led_sel), .penable (penable), .pwrite (pwrite),
		.pwdata  (pwdata ), .pstrb   (pstrb  ),
		.rdata   (led_rdata), .led   (led    )
	);

	sysctl_regs i_sysctl_regs (
		.clk     (clk    ), .rst_n   (rst_n  ),
		.sel     (sys_sel), .penable (penable), .pwrite (pwrite),
		.paddr   (paddr  ), .pwdata  (pwdata ), .pstrb  (pstrb ),
		.rdata   (sys_rdata)
	);

endmodule

/* test/periph_assert.sv */
`timescale 1ns/1ps

module periph_assert import soc_pkg::*; (
	input logic    clk,
	input logic    rst_n,
	input logic    awvalid,
	input logic    awready,
	input logic    wvalid,
	input logic    wready,
	input logic    arvalid,
	input logic    arready,
	input logic    bvalid,
	input logic    bready,
	input axi_id_t bid,
	input resp_t   bresp,
	input logic    rvalid,
	input logic    rready,
	input axi_id_t rid,
	input data_t   rdata,
	input resp_t   rresp
);

	// read back by the testbench at the end
	int fail_count = 0;

	// no response leaves reset
	reset_quiet: assert property (@(posedge clk) !rst_n |=> !bvalid && !rvalid)
		else begin fail_count++; $error("response valid right after reset"); end

	// stalled b stays put
	b_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp))
		else begin fail_count++; $error("write response changed while stalled"); end

	r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rid) && $stable(rdata) && $stable(rresp))
		else begin fail_count++; $error("read response changed while stalled"); end

	// setup, access, then resp
	b_latency: assert property (@(posedge clk) disable iff (!rst_n)
		awvalid && awready |-> ##3 $rose(bvalid))
		else begin fail_count++; $error("write response not 3 cycles after accept"); end

	r_latency: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && arready |-> ##3 $rose(rvalid))
		else begin fail_count++; $error("read response not 3 cycles after accept"); end

	// one in flight
	busy_block: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid || rvalid |-> !awready && !wready && !arready)
		else begin fail_count++; $error("request accepted while response pending"); end

	// write wins when both are offered
	write_first: assert property (@(posedge clk) disable iff (!rst_n)
		awvalid && wvalid |-> !arready && (awready == wready))
		else begin fail_count++; $error("read accepted over a pending write"); end

endmodule

bind periph_top periph_assert i_periph_assert (.*);

/* test/tb_periph_top.sv */
`timescale 1ns/1ps

`include "soc_config.svh"

module tb_periph_top import soc_pkg::*; ();

	localparam int RESET_CYCLES = 3;
	// transactions issued by the sequence below
	localparam int TXN_COUNT    = 41;

	logic    clk;
	logic    rst_n;
	logic    awvalid, wvalid, bready, arvalid, rready;
	axi_id_t awid, arid;
	addr_t   awaddr, araddr;
	data_t   wdata;
	strb_t   wstrb;
	logic    awready, wready, bvalid, arready, rvalid;
	axi_id_t bid, rid;
	resp_t   bresp, rresp;
	data_t   rdata;
	led_t    led;

	// reference state of the two slaves
	led_t        led_model;
	data_t       scratch_model;
	integer      seed;
	int unsigned checks;
	int unsigned errors;
	int unsigned accept_seq;
	int unsigned wr_order;
	int unsigned rd_order;

	periph_top i_dut (.*);

	always #2 clk = ~clk;

	function automatic resp_t expected_resp(input addr_t addr);
		int unsigned slot;
		if (addr < `APB_ADDR_BASE || addr > `APB_ADDR_END) begin
			return `RESP_DECERR;
		end
		slot = (addr - `APB_ADDR_BASE) >> `APB_SLOT_BITS;
		if (slot == `APB_SLOT_LED || slot == `APB_SLOT_SYSCTL) begin
			return `RESP_OKAY;
		end
		return `RESP_SLVERR;
	endfunction

	function automatic data_t expected_rdata(input addr_t addr);
		int unsigned slot;
		int unsigned word;
		if (expected_resp(addr) != `RESP_OKAY) begin
			return '0;
		end
		slot = (addr - `APB_ADDR_BASE) >> `APB_SLOT_BITS;
		word = (addr & ((1 << `APB_SLOT_BITS) - 1)) >> 2;
		if (slot == `APB_SLOT_LED) begin
			return data_t'(led_model);
		end
		// id word, then scratch, then zeros
		if (word == 0) begin
			return `SYSCTL_ID;
		end
		return (word == 1) ? scratch_model : '0;
	endfunction

	function automatic void apply_write(input addr_t addr, input data_t data, input strb_t strb);
		int unsigned slot;
		int unsigned word;
		if (expected_resp(addr) != `RESP_OKAY) begin
			return;
		end
		slot = (addr - `APB_ADDR_BASE) >> `APB_SLOT_BITS;
		word = (addr & ((1 << `APB_SLOT_BITS) - 1)) >> 2;
		if (slot == `APB_SLOT_LED && strb[0]) begin
			led_model = data[`LED_COUNT-1:0];
		end else if (slot == `APB_SLOT_SYSCTL && word == 1) begin
			// byte lanes merge one by one
			for (int i = 0; i < `STRB_WIDTH; i++) begin
				if (strb[i]) begin
					scratch_model[8*i +: 8] = data[8*i +: 8];
				end
			end
		end
	endfunction

	task automatic check_value(input string name, input data_t exp, input data_t act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic write_txn(input string name, input axi_id_t id, input addr_t addr,
			input data_t data, input strb_t strb);
		logic  taken;
		resp_t exp_resp;
		exp_resp = expected_resp(addr);
		@(negedge clk);
		awvalid = 1'b1;
		wvalid  = 1'b1;
		awid    = id;
		awaddr  = addr;
		wdata   = data;
		wstrb   = strb;
		// mid low phase, ready is settled
		taken = 1'b0;
		while (!taken) begin
			#1;
			taken = awready & wready;
			@(negedge clk);
		end
		accept_seq++;
		wr_order = accept_seq;
		awvalid  = 1'b0;
		wvalid   = 1'b0;
		apply_write(addr, data, strb);
		taken = 1'b0;
		while (!taken) begin
			// stall about one cycle in four
			bready = ($random(seed) & 3) != 0;
			#1;
			taken = bvalid & bready;
			if (taken) begin
				check_value({name, " bid"}, data_t'(id), data_t'(bid));
				check_value({name, " bresp"}, data_t'(exp_resp), data_t'(bresp));
				check_value({name, " led"}, data_t'(led_model), data_t'(led));
			end
			@(negedge clk);
		end
		bready = 1'b0;
	endtask

	task automatic read_txn(input string name, input axi_id_t id, input addr_t addr);
		logic  taken;
		data_t exp_data;
		@(negedge clk);
		arvalid = 1'b1;
		arid    = id;
		araddr  = addr;
		taken   = 1'b0;
		while (!taken) begin
			#1;
			taken = arready;
			@(negedge clk);
		end
		accept_seq++;
		rd_order = accept_seq;
		arvalid  = 1'b0;
		// model state as of acceptance
		exp_data = expected_rdata(addr);
		taken    = 1'b0;
		while (!taken) begin
			rready = ($random(seed) & 3) != 0;
			#1;
			taken = rvalid & rready;
			if (taken) begin
				check_value({name, " rid"}, data_t'(id), data_t'(rid));
				check_value({name, " rresp"}, data_t'(expected_resp(addr)), data_t'(rresp));
				check_value({name, " rdata"}, exp_data, rdata);
			end
			@(negedge clk);
		end
		rready = 1'b0;
	endtask

	initial begin
		data_t   val;
		axi_id_t id_a;
		axi_id_t id_b;
		clk = 1'b0;
		rst_n = 1'b0;
		{awvalid, wvalid, bready, arvalid, rready} = '0;
		{awid, arid, awaddr, araddr, wdata, wstrb} = '0;
		led_model = '0;
		scratch_model = '0;
		seed = 90;
		{checks, errors, accept_seq, wr_order, rd_order} = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		check_value("reset led", '0, data_t'(led));

		// led slot, any offset
		write_txn("led write", 4'h1, `APB_ADDR_BASE, 32'h0000_00A5, 4'h1);
		write_txn("led offset write", 4'h2, `APB_ADDR_BASE + 32'h10, 32'h0000_003C, 4'h1);
		read_txn("led readback", 4'h3, `APB_ADDR_BASE);

		// scratch with mixed strobes
		write_txn("scratch full", 4'h4, `APB_ADDR_BASE + 32'h1004, 32'h1122_3344, 4'hF);
		read_txn("scratch full rd", 4'h5, `APB_ADDR_BASE + 32'h1004);
		write_txn("scratch even", 4'h6, `APB_ADDR_BASE + 32'h1004, 32'hAABB_CCDD, 4'h5);
		read_txn("scratch even rd", 4'h7, `APB_ADDR_BASE + 32'h1004);
		write_txn("scratch odd", 4'h8, `APB_ADDR_BASE + 32'h1004, 32'h5566_7788, 4'hA);
		read_txn("scratch odd rd", 4'h9, `APB_ADDR_BASE + 32'h1004);

		// id word ignores writes
		read_txn("id read", 4'hA, `APB_ADDR_BASE + 32'h1000);
		write_txn("id write", 4'hB, `APB_ADDR_BASE + 32'h1000, 32'hFFFF_FFFF, 4'hF);
		read_txn("id reread", 4'hC, `APB_ADDR_BASE + 32'h1000);
		read_txn("sysctl hole", 4'hD, `APB_ADDR_BASE + 32'h1008);

		// empty slot and outside the window
		read_txn("empty slot rd", 4'hE, `APB_ADDR_BASE + 32'h2000);
		write_txn("empty slot wr", 4'hF, `APB_ADDR_BASE + 32'h5000, 32'h0000_000F, 4'hF);
		write_txn("outside wr", 4'h0, 32'h2000_0000, 32'h0000_000F, 4'hF);
		read_txn("outside rd", 4'h1, 32'h1000_0000);

		// ids echoed back
		for (int i = 0; i < 8; i++) begin
			id_a = axi_id_t'($random(seed));
			id_b = axi_id_t'($random(seed));
			val  = $random(seed);
			write_txn("id echo wr", id_a, `APB_ADDR_BASE, val, 4'h1);
			read_txn("id echo rd", id_b, `APB_ADDR_BASE);
		end

		// write and read offered together, write goes first
		for (int i = 0; i < 4; i++) begin
			val = $random(seed);
			fork
				write_txn("race wr", 4'h3, `APB_ADDR_BASE, val, 4'h1);
				read_txn("race rd", 4'h4, `APB_ADDR_BASE);
			join
			check_value("race order", 32'd1, data_t'(wr_order < rd_order));
		end

		repeat (5) @(negedge clk);
		$display("checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, i_dut.i_periph_assert.fail_count);
		if (errors == 0 && i_dut.i_periph_assert.fail_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		repeat (RESET_CYCLES + 200 * TXN_COUNT) @(posedge clk);
		$display("watchdog: run timed out before the sequence finished");
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+logic
logic/soc_pkg.sv
logic/bridge_ctrl.sv
logic/axi_req_buf.sv
logic/apb_mux.sv
logic/led_regs.sv
logic/sysctl_regs.sv
logic/periph_top.sv
test/periph_assert.sv
test/tb_periph_top.sv

/* run.sh */
#!/bin/sh
# build and run the periph_top testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_periph_top -f verilog.f \
	-o sim_tb > build.log 2>&1 \
	&& ./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 \
	&& ! grep -q "TEST FAILED" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see build.log and sim.log"; exit 1; }
